//--- compile.f
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/echo_queue.sv
source/uart_echo_top.sv
verification/uart_echo_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the echo subsystem with its testbench, then run the simulation
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module uart_echo_tb -f compile.f

# the result comes from the simulation output, not from its exit status
output=$(./obj_dir/Vuart_echo_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- verification/uart_echo_tb.sv
/*
 * uart_echo_tb
 * table-driven testbench for the serial echo subsystem, sends frames on rx_pin
 * and decodes the echoes on tx_pin against a model of the echo FIFO
 */
module uart_echo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;

    localparam int clks_per_bit = 16;
    localparam int fifo_depth   = 4;
    localparam int num_rows     = 16;

    typedef struct packed {
        logic [byte_width-1:0] data;
        logic                  good_stop; // low sends a bad stop bit
        logic                  cts_level;
        logic [3:0]            gap_bits;  // idle line after the frame
        logic                  glitch;    // short low pulse instead of a frame
    } row_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  rx_pin;
    logic                  cts;
    logic                  tx_pin;
    logic                  rx_flag;
    logic [byte_width-1:0] rx_byte;
    logic                  frame_error;
    logic                  overrun;

    row_t                  rows [num_rows];
    logic [byte_width-1:0] echo_q [$];     // bytes still expected on tx_pin
    logic [byte_width-1:0] last_good = '0; // rx_byte holds this after a bad frame
    int                    accepted_cnt = 0;
    int                    started_cnt = 0;
    int                    exp_overrun = 0;
    int                    flag_cnt = 0;
    int                    error_cnt = 0;
    int                    overrun_cnt = 0;
    int                    cycle_cnt = 0;
    int                    timeout_limit = 0;
    bit                    decode_on = 1'b0;

    uart_echo_top #(
        .clks_per_bit (clks_per_bit),
        .fifo_depth   (fifo_depth)
    ) uart_echo_i (
        .clk         (clk),
        .reset       (reset),
        .rx_pin      (rx_pin),
        .cts         (cts),
        .tx_pin      (tx_pin),
        .rx_flag     (rx_flag),
        .rx_byte     (rx_byte),
        .frame_error (frame_error),
        .overrun     (overrun)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic row_t make_row(input logic [7:0] data, input logic good_stop,
                                      input logic cts_level, input logic [3:0] gap_bits,
                                      input logic glitch);
        return '{data: data, good_stop: good_stop, cts_level: cts_level,
                 gap_bits: gap_bits, glitch: glitch};
    endfunction

    function automatic void build_table();
        logic [31:0] rng;
        rng = 32'h16f7;
        rows[0] = make_row(8'h00, 1'b1, 1'b1, 4'd1, 1'b0);
        rows[1] = make_row(8'hff, 1'b1, 1'b1, 4'd1, 1'b0);
        rows[2] = make_row(8'h55, 1'b1, 1'b1, 4'd1, 1'b0);
        for (int i = 3; i < 7; i++) begin
            rng = next_random(rng);
            rows[i] = make_row(rng[23:16], 1'b1, 1'b1, rng[8] ? 4'd2 : 4'd1, 1'b0);
        end
        rng = next_random(rng);
        rows[7] = make_row(rng[23:16], 1'b0, 1'b1, 4'd2, 1'b0); // low stop bit
        // quiet line long enough for a false start to finish a whole frame
        rows[8] = make_row(8'h00, 1'b1, 1'b1, 4'd12, 1'b1);
        // five bytes with cts low, the last one finds the FIFO full
        for (int i = 9; i < 14; i++) begin
            rng = next_random(rng);
            rows[i] = make_row(rng[23:16], 1'b1, 1'b0, 4'd1, 1'b0);
        end
        for (int i = 14; i < num_rows; i++) begin
            rng = next_random(rng);
            rows[i] = make_row(rng[23:16], 1'b1, 1'b1, 4'd2, 1'b0);
        end
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("error: %s is %h, expected %h", name, got, expected);
            stop_run();
        end
    endtask

    // one level per cycle, changed right after the rising edge
    task automatic hold_line(input logic level, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            rx_pin <= level;
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic good_stop);
        hold_line(1'b0, clks_per_bit);
        for (int i = 0; i < byte_width; i++) begin
            hold_line(data[i], clks_per_bit); // LSB first
        end
        hold_line(good_stop, clks_per_bit);
    endtask

    task automatic wait_rx_result(input int events_before);
        int waited;
        waited = 0;
        while (flag_cnt + error_cnt == events_before) begin
            assert (waited < 2 * clks_per_bit) else begin
                report_failure("the receiver reported nothing after a full frame");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic run_row(input row_t row);
        int flags_before;
        int errors_before;
        flags_before  = flag_cnt;
        errors_before = error_cnt;
        @(posedge clk);
        cts <= row.cts_level;
        if (row.glitch) begin
            hold_line(1'b0, clks_per_bit / 4); // well under half a bit
            hold_line(1'b1, int'(row.gap_bits) * clks_per_bit);
            check_value("rx_flag pulses", flag_cnt, flags_before);
            check_value("frame_error pulses", error_cnt, errors_before);
        end else begin
            send_frame(row.data, row.good_stop);
            hold_line(1'b1, int'(row.gap_bits) * clks_per_bit);
            wait_rx_result(flags_before + errors_before);
            if (row.good_stop) begin
                check_value("rx_flag pulses", flag_cnt, flags_before + 1);
                check_value("frame_error pulses", error_cnt, errors_before);
                check_value("rx_byte", 32'(rx_byte), 32'(row.data));
                last_good = row.data;
                // bytes accepted but not yet on tx_pin are what the FIFO holds
                if (accepted_cnt - started_cnt >= fifo_depth) begin
                    exp_overrun++;
                end else begin
                    echo_q.push_back(row.data);
                    accepted_cnt++;
                end
            end else begin
                check_value("frame_error pulses", error_cnt, errors_before + 1);
                check_value("rx_flag pulses", flag_cnt, flags_before);
                check_value("rx_byte", 32'(rx_byte), 32'(last_good));
            end
        end
        check_value("overrun pulses", overrun_cnt, exp_overrun);
    endtask

    // samples tx_pin in the middle of each bit
    task automatic decode_echo();
        logic [byte_width-1:0] data;
        logic [byte_width-1:0] expected;
        @(posedge clk);
        while (tx_pin !== 1'b0) begin
            @(posedge clk);
        end
        started_cnt++;
        // queued bytes may only leave while cts is high
        assert (cts === 1'b1) else begin
            report_failure("a frame started on tx_pin while cts was low");
        end
        repeat (clks_per_bit / 2 - 1) @(posedge clk);
        check_value("tx_pin start bit", 32'(tx_pin), 32'h0);
        for (int i = 0; i < byte_width; i++) begin
            repeat (clks_per_bit) @(posedge clk);
            data[i] = tx_pin;
        end
        repeat (clks_per_bit) @(posedge clk);
        check_value("tx_pin stop bit", 32'(tx_pin), 32'h1);
        assert (echo_q.size() > 0) else begin
            report_failure("a frame appeared on tx_pin with no byte left to echo");
        end
        expected = echo_q.pop_front();
        check_value("tx_pin data", 32'(data), 32'(expected));
    endtask

    always @(posedge clk) begin
        if (reset === 1'b0) begin
            if (rx_flag) begin
                flag_cnt++;
            end
            if (frame_error) begin
                error_cnt++;
            end
            if (overrun) begin
                overrun_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
            report_failure("the run did not finish within its cycle limit");
        end
    end

    initial begin
        wait (decode_on);
        forever begin
            decode_echo();
        end
    end

    initial begin
        int gap_sum;
        reset  = 1'b1;
        rx_pin = 1'b1;
        cts    = 1'b1;
        build_table();
        gap_sum = 0;
        for (int r = 0; r < num_rows; r++) begin
            gap_sum += int'(rows[r].gap_bits);
        end
        // 12 bit periods per row plus its gap, then the drain of a full FIFO
        timeout_limit = (num_rows * 12 + gap_sum + (fifo_depth + 2) * 10 + 24) * clks_per_bit;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("tx_pin", 32'(tx_pin), 32'h1);
        check_value("rx_flag", 32'(rx_flag), 32'h0);
        check_value("frame_error", 32'(frame_error), 32'h0);
        check_value("overrun", 32'(overrun), 32'h0);
        check_value("rx_byte", 32'(rx_byte), 32'h0);
        decode_on = 1'b1;

        for (int r = 0; r < num_rows; r++) begin
            run_row(rows[r]);
        end

        while (echo_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (12 * clks_per_bit) @(posedge clk); // line must stay quiet
        check_value("echo frames", started_cnt, accepted_cnt);
        check_value("overrun pulses", overrun_cnt, exp_overrun);
        $display("Test OK");
        $finish;
    end

endmodule

//--- source/uart_echo_top.sv
/*
 * uart_echo_top
 * serial echo subsystem, received bytes are queued and sent back on tx_pin
 */
module uart_echo_top #(
    parameter int unsigned clks_per_bit = 868, // 115200 baud at 100 MHz
    parameter int unsigned fifo_depth   = 4    // power of two
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rx_pin,
    input  logic                            cts,
    output logic                            tx_pin,
    output logic                            rx_flag,
    output logic [uart_pkg::byte_width-1:0] rx_byte,
    output logic                            frame_error,
    output logic                            overrun
);
    import uart_pkg::*;

    logic                  tx_start;
    logic [byte_width-1:0] tx_byte;
    logic                  tx_busy;

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) uart_rx_i (
        .clk         (clk),
        .reset       (reset),
        .rx_pin      (rx_pin),
        .rx_flag     (rx_flag),
        .frame_error (frame_error),
        .rx_byte     (rx_byte)
    );

    echo_queue #(
        .fifo_depth (fifo_depth)
    ) echo_queue_i (
        .clk      (clk),
        .reset    (reset),
        .rx_flag  (rx_flag),
        .rx_byte  (rx_byte),
        .tx_busy  (tx_busy),
        .cts      (cts),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .overrun  (overrun)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_i (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_pin   (tx_pin),
        .tx_busy  (tx_busy)
    );

endmodule

//--- source/echo_queue.sv
/*
 * echo_queue
 * small FIFO between receiver and transmitter, drops bytes with an overrun pulse
 * when full and starts the transmitter while cts is high
 */
module echo_queue #(
    parameter int unsigned fifo_depth = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rx_flag,  // write strobe from the receiver
    input  logic [uart_pkg::byte_width-1:0] rx_byte,
    input  logic                            tx_busy,
    input  logic                            cts,      // clear-to-send level
    output logic                            tx_start, // one-cycle start pulse
    output logic [uart_pkg::byte_width-1:0] tx_byte,
    output logic                            overrun   // one-cycle pulse per dropped byte
);
    import uart_pkg::*;

    localparam int unsigned ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int unsigned cnt_w = ptr_w + 1;
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(fifo_depth);

    logic [byte_width-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      count;
    logic                  full;
    logic                  empty;
    logic                  wr_en;
    logic                  rd_en;

    assign full  = (count == full_cnt);
    assign empty = (count == '0);
    assign wr_en = rx_flag && !full;

    // busy only rises the cycle after tx_start, so the start pulse itself
    // blocks a second pop in that gap
    assign rd_en = !empty && !tx_busy && cts && !tx_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            tx_start <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            tx_start <= rd_en;
            overrun  <= rx_flag && full; // contents stay as they are

            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // storage and the head byte handed to the transmitter
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= rx_byte;
        end
        if (rd_en) begin
            tx_byte <= mem[rd_ptr]; // valid together with tx_start
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= full_cnt);

endmodule

//--- source/uart_tx.sv
/*
 * uart_tx
 * 8N1 serial transmitter, sends one frame per start pulse and holds busy until
 * the stop bit has finished
 */
module uart_tx #(
    parameter int unsigned clks_per_bit = 868
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            tx_start, // one-cycle request, byte sampled here
    input  logic [uart_pkg::byte_width-1:0] tx_byte,
    output logic                            tx_pin,
    output logic                            tx_busy
);
    import uart_pkg::*;

    localparam int unsigned cnt_w = $clog2(clks_per_bit);
    localparam int unsigned idx_w = $clog2(byte_width);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [idx_w-1:0] last_idx = idx_w'(byte_width - 1);

    tx_state_t             state;
    logic [cnt_w-1:0]      bit_cnt;
    logic [idx_w-1:0]      bit_idx;
    logic [byte_width-1:0] shift_reg;

    assign tx_busy = (state != tx_idle);

    // the start-bit state is named by its package path, the port shares its name
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= tx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_pin  <= 1'b1; // line idles high
        end else begin
            case (state)
                tx_idle: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (tx_start) begin
                        state  <= uart_pkg::tx_start;
                        tx_pin <= 1'b0; // start bit from the next cycle on
                    end
                end
                uart_pkg::tx_start: begin
                    if (bit_cnt == last_cnt) begin
                        bit_cnt <= '0;
                        state   <= tx_data;
                        tx_pin  <= shift_reg[0];
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                tx_data: begin
                    if (bit_cnt == last_cnt) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_idx) begin
                            state  <= tx_stop;
                            tx_pin <= 1'b1;
                        end else begin
                            tx_pin <= shift_reg[1]; // next bit before the shift lands
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                tx_stop: begin
                    if (bit_cnt == last_cnt) begin
                        bit_cnt <= '0;
                        state   <= tx_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // byte latched on the request, shifted right after each data bit
    always_ff @(posedge clk) begin
        if (state == tx_idle && tx_start) begin
            shift_reg <= tx_byte;
        end else if (state == tx_data && bit_cnt == last_cnt) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy);

endmodule

//--- source/uart_rx.sv
/*
 * uart_rx
 * 8N1 serial receiver, confirms the start bit at mid-bit and samples each bit there.
 * Reports the byte with a one-cycle flag, or a frame error when the stop bit is low.
 */
module uart_rx #(
    parameter int unsigned clks_per_bit = 868
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rx_pin,
    output logic                            rx_flag,     // one cycle per accepted byte
    output logic                            frame_error, // one cycle on a low stop bit
    output logic [uart_pkg::byte_width-1:0] rx_byte      // last accepted byte
);
    import uart_pkg::*;

    localparam int unsigned cnt_w = $clog2(clks_per_bit);
    localparam int unsigned idx_w = $clog2(byte_width);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [idx_w-1:0] last_idx = idx_w'(byte_width - 1);

    rx_state_t             state;
    logic [cnt_w-1:0]      bit_cnt;
    logic [idx_w-1:0]      bit_idx;
    logic [byte_width-1:0] shift_reg;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_last;  // previous synchronized sample
    logic                  start_edge;

    // two flops against metastability, a third to see the falling edge
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx_pin;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    // a start needs a high-to-low step, so a line stuck low after a bad
    // stop bit does not retrigger the receiver
    assign start_edge = rx_last && !rx_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= rx_idle;
            bit_cnt     <= '0;
            bit_idx     <= '0;
            rx_flag     <= 1'b0;
            frame_error <= 1'b0;
            rx_byte     <= '0;
        end else begin
            rx_flag     <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    if (start_edge) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (bit_cnt == half_cnt) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // high at mid start bit is a glitch
                        state   <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_cnt == last_cnt) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_idx) begin
                            state <= rx_stop;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_cnt == last_cnt) begin
                        bit_cnt <= '0;
                        state   <= rx_idle;
                        if (rx_sync) begin
                            rx_byte <= shift_reg;
                            rx_flag <= 1'b1;
                        end else begin
                            frame_error <= 1'b1; // old byte is kept
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data path, bits enter at the top and end up LSB first
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_cnt == last_cnt) begin
            shift_reg <= {rx_sync, shift_reg[byte_width-1:1]};
        end
    end

    a_rx_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rx_flag && frame_error));

    a_rx_flag_pulse: assert property (@(posedge clk) disable iff (reset)
        rx_flag |=> !rx_flag);

    a_frame_error_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_error |=> !frame_error);

endmodule

//--- source/uart_pkg.sv
/*
 * uart_pkg
 * shared frame width and FSM encodings for the 8N1 echo subsystem
 */
package uart_pkg;

    // data bits per frame, no parity
    localparam int unsigned byte_width = 8;

    // receiver FSM
    typedef enum logic [1:0] {
        rx_idle  = 2'd0, // waiting for a falling edge on the line
        rx_start = 2'd1, // confirming the start bit at mid-bit
        rx_data  = 2'd2, // shifting in data bits, LSB first
        rx_stop  = 2'd3  // sampling the stop bit
    } rx_state_t;

    // transmitter FSM
    typedef enum logic [1:0] {
        tx_idle  = 2'd0, // line held high, ready for a start pulse
        tx_start = 2'd1, // driving the start bit low
        tx_data  = 2'd2, // driving data bits, LSB first
        tx_stop  = 2'd3  // driving the stop bit high
    } tx_state_t;

endpackage
